// File: include/video_settings.svh
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster geometry in pixel ticks and lines.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HTOTAL      512
`define VTOTAL      262

// horizontal blanking covers hdump >= HB_START and hdump < HB_END.
`define HB_START    448
`define HB_END      64

// horizontal sync lasts 36 ticks around the line wrap.
`define HS_SET      'h1DC
`define HS_CLR      0

// vertical sync is set on line 0x100 and cleared on line 1.
`define VS_SET      'h100
`define VS_CLR      1

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lines VB_FIRST to VB_LAST are the 224 visible lines.
`define VB_FIRST    15
`define VB_LAST     238

// colour code that lets the layer below show through.
`define TRANSPARENT 15

// line shown by vdump right after reset.
`define VRESET      261

`endif

// File: source/videoTimingPkg.sv
`include "video_settings.svh"

package videoTimingPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter widths follow the raster size.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int hWidth = $clog2(`HTOTAL);    // 9 bits cover 512 pixel ticks.
    localparam int vWidth = $clog2(`VTOTAL);    // 9 bits cover 262 lines.

    // horizontal position within a line.
    typedef logic [hWidth-1:0] hcount_t;

    // line number within a frame.
    typedef logic [vWidth-1:0] vcount_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line buffers alternate banks on every line.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic lineBank(vcount_t line);
        return line[0];                         // even and odd lines use opposite banks.
    endfunction

endpackage

// File: source/videoPixelPkg.sv
`include "video_settings.svh"

package videoPixelPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field widths shared by every pixel format.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int palWidth    = 5;             // palette select within a layer.
    localparam int colourWidth = 4;             // colour code within a palette.

    typedef logic [palWidth-1:0]    palette_t;
    typedef logic [colourWidth-1:0] colour_t;

    // layer code carried in the top bits of the output index.
    typedef enum logic [1:0] {
        layerBack = 2'd0,                       // backdrop fill.
        layerScr  = 2'd1,                       // scroll layer.
        layerObj  = 2'd2                        // object layer.
    } layer_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // colour sits in the low bits of every struct.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        palette_t pal;                          // scroll palette.
        colour_t  colour;                       // scroll colour code.
    } scrPixel_t;

    typedef struct packed {
        logic     prio;                         // set when the object sits above scroll.
        palette_t pal;                          // object palette.
        colour_t  colour;                       // object colour code.
    } objPixel_t;

    typedef struct packed {
        layer_e   layer;                        // layer that won the pixel.
        palette_t pal;                          // palette of the winning layer.
        colour_t  colour;                       // colour of the winning layer.
    } palIndex_t;

    function automatic logic isOpaque(colour_t colour);
        return colour != colour_t'(`TRANSPARENT); // code 15 shows the layer below.
    endfunction

endpackage

// File: source/cpsTiming.sv
`include "video_settings.svh"

module cpsTiming (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cen8,
    output videoTimingPkg::hcount_t hdump,
    output videoTimingPkg::vcount_t vdump,
    output videoTimingPkg::vcount_t vrender,
    output videoTimingPkg::vcount_t vrender1,
    output logic                    start,
    output logic                    hs,
    output logic                    vs,
    output logic                    hb,
    output logic                    vb
);

    import videoTimingPkg::*;

    logic preVb;                                // vertical blank staged for the next line.
    logic lineEnd;                              // last tick of the current line.
    logic hBlankNext;                           // horizontal blank for the current position.
    logic vBlankNext;                           // vertical blank for the shown line.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode of the current counter values.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign lineEnd    = hdump == hcount_t'(`HTOTAL - 1);
    assign hBlankNext = (hdump >= hcount_t'(`HB_START)) || (hdump < hcount_t'(`HB_END));
    assign vBlankNext = (vdump < vcount_t'(`VB_FIRST)) || (vdump > vcount_t'(`VB_LAST));

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump    <= '0;
            vdump    <= vcount_t'(`VRESET);     // the frame opens inside vertical blank.
            vrender  <= '0;
            vrender1 <= '0;
            start    <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
            hb       <= 1'b1;
            vb       <= 1'b1;
            preVb    <= 1'b1;
        end else if (cen8) begin
            start <= lineEnd;                   // one tick pulse as the new line opens.
            hb    <= hBlankNext;                // lags the counter by one tick.
            preVb <= vBlankNext;                // only reaches vb at the line wrap.

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // sync pulses.
            if (hdump == hcount_t'(`HS_SET)) begin
                hs <= 1'b1;                     // 36 ticks before the wrap.
            end else if (hdump == hcount_t'(`HS_CLR)) begin
                hs <= 1'b0;                     // ends one tick into the new line.
            end
            if (vdump == vcount_t'(`VS_SET)) begin
                vs <= 1'b1;
            end else if (vdump == vcount_t'(`VS_CLR)) begin
                vs <= 1'b0;
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // line counters form a chain so the renderer works one line ahead.
            if (lineEnd) begin
                hdump    <= '0;
                vrender1 <= (vrender1 == vcount_t'(`VTOTAL - 1)) ? '0 : vrender1 + 1'b1;
                vrender  <= vrender1;           // line being written to the buffers.
                vdump    <= vrender;            // line being read out and shown.
                vb       <= preVb;              // blank state of the line just finished.
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

endmodule

// File: source/cpsVideoRegs.sv
module cpsVideoRegs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    regWrite,
    input  logic [2:0]              regAddr,
    input  logic [15:0]             regData,
    output videoPixelPkg::palIndex_t backdrop,
    output logic                    scrEnable,
    output logic                    objEnable
);

    import videoPixelPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [2:0] backdropAddr = 3'd0; // palette and colour of the backdrop.
    localparam logic [2:0] enableAddr   = 3'd1; // bit 0 scroll on, bit 1 objects on.

    localparam int colourTop = colourWidth - 1;            // msb of the colour field.
    localparam int palTop    = palWidth + colourWidth - 1; // msb of the palette field.

    always_ff @(posedge clk) begin
        if (reset) begin
            backdrop  <= '0;                    // layer code zero marks the backdrop.
            scrEnable <= 1'b1;                  // both layers show after reset.
            objEnable <= 1'b1;
        end else if (regWrite) begin
            case (regAddr)
                backdropAddr: begin
                    backdrop.layer  <= layerBack;  // the layer code is fixed here.
                    backdrop.pal    <= regData[palTop:colourWidth];
                    backdrop.colour <= regData[colourTop:0];
                end
                enableAddr: begin
                    scrEnable <= regData[0];    // scroll layer on.
                    objEnable <= regData[1];    // object layer on.
                end
                default: begin
                    // other addresses have no register behind them.
                end
            endcase
        end
    end

endmodule

// File: source/cpsLineBuffer.sv
`include "video_settings.svh"

module cpsLineBuffer #(
    parameter type pixel_t = logic [8:0]
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cen8,
    input  logic                    write,
    input  videoTimingPkg::hcount_t writeAddr,
    input  pixel_t                  writeData,
    input  logic                    writeBank,
    input  logic                    readBank,
    input  videoTimingPkg::hcount_t readAddr,
    output pixel_t                  readData
);

    import videoTimingPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two banks of one line each.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int depth = 2 * `HTOTAL;         // bank select is the top address bit.
    localparam pixel_t blank = pixel_t'($bits(pixel_t)'(`TRANSPARENT)); // colour bits all set.

    pixel_t          mem [depth];               // line storage for both banks.
    logic [hWidth:0] clearAddr;                 // sweep pointer after reset.
    logic            clearing;                  // high while the sweep runs.
    logic [hWidth:0] writeIndex;                // bank and position of a renderer write.
    logic [hWidth:0] readIndex;                 // bank and position of the readout.

    assign writeIndex = {writeBank, writeAddr};
    assign readIndex  = {readBank, readAddr};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the reset sweep visits every location once.
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing  <= 1'b1;
            clearAddr <= '0;
        end else if (clearing) begin
            clearAddr <= clearAddr + 1'b1;
            if (&clearAddr) begin
                clearing <= 1'b0;               // 1024 clocks cover both banks.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage with clear on read.
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clearAddr] <= blank;            // sweep write comes first.
        end
        if (write) begin
            mem[writeIndex] <= writeData;       // renderer strobes ignore cen8.
        end
        if (cen8 && !clearing) begin
            readData       <= mem[readIndex];   // one tick behind the read address.
            mem[readIndex] <= blank;            // the slot is empty for the line after next.
        end
    end

endmodule

// File: source/cpsLayerMix.sv
module cpsLayerMix (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cen8,
    input  videoPixelPkg::scrPixel_t scrPixel,
    input  videoPixelPkg::objPixel_t objPixel,
    input  videoPixelPkg::palIndex_t backdrop,
    input  logic                     scrEnable,
    input  logic                     objEnable,
    input  logic                     hs,
    input  logic                     vs,
    input  logic                     hb,
    input  logic                     vb,
    output videoPixelPkg::palIndex_t pixIndex,
    output logic                     hsOut,
    output logic                     vsOut,
    output logic                     hbOut,
    output logic                     vbOut
);

    import videoPixelPkg::*;

    logic      hsDelay;                         // first stage of the sync delay.
    logic      vsDelay;
    logic      hbDelay;                         // first stage of the blank delay.
    logic      vbDelay;
    logic      blanking;                        // blank state that matches the pixel.
    logic      scrShows;                        // scroll pixel is on and opaque.
    logic      objWins;                         // object pixel takes the position.
    palIndex_t mixIndex;                        // result before the output register.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority rule.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign blanking = hbDelay || vbDelay;       // same blank that reaches hbOut and vbOut.
    assign scrShows = scrEnable && isOpaque(scrPixel.colour);
    assign objWins  = objEnable && isOpaque(objPixel.colour) && (objPixel.prio || !scrShows);

    always_comb begin
        if (blanking) begin
            mixIndex = backdrop;                // blanking shows only the backdrop.
        end else if (objWins) begin
            mixIndex = '{layer: layerObj, pal: objPixel.pal, colour: objPixel.colour};
        end else if (scrShows) begin
            mixIndex = '{layer: layerScr, pal: scrPixel.pal, colour: scrPixel.colour};
        end else begin
            mixIndex = backdrop;                // nothing opaque on this position.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stage two ticks behind hdump.
    always_ff @(posedge clk) begin
        if (reset) begin
            pixIndex <= '0;                     // matches the backdrop after reset.
            hsDelay  <= 1'b0;
            vsDelay  <= 1'b0;
            hbDelay  <= 1'b1;
            vbDelay  <= 1'b1;
            hsOut    <= 1'b0;
            vsOut    <= 1'b0;
            hbOut    <= 1'b1;
            vbOut    <= 1'b1;
        end else if (cen8) begin
            pixIndex <= mixIndex;               // the buffers already spent one tick.
            hsDelay  <= hs;
            vsDelay  <= vs;
            hbDelay  <= hb;
            vbDelay  <= vb;
            hsOut    <= hsDelay;                // two ticks keep sync in step with colour.
            vsOut    <= vsDelay;
            hbOut    <= hbDelay;
            vbOut    <= vbDelay;
        end
    end

endmodule

// File: source/cpsVideo.sv
module cpsVideo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cen8,
    input  logic                     scrWrite,
    input  videoTimingPkg::hcount_t  scrAddr,
    input  videoPixelPkg::scrPixel_t scrPixel,
    input  logic                     objWrite,
    input  videoTimingPkg::hcount_t  objAddr,
    input  videoPixelPkg::objPixel_t objPixel,
    input  logic                     regWrite,
    input  logic [2:0]               regAddr,
    input  logic [15:0]              regData,
    output videoTimingPkg::hcount_t  hdump,
    output videoTimingPkg::vcount_t  vdump,
    output videoTimingPkg::vcount_t  vrender,
    output videoTimingPkg::vcount_t  vrender1,
    output logic                     start,
    output videoPixelPkg::palIndex_t pixIndex,
    output logic                     hsOut,
    output logic                     vsOut,
    output logic                     hbOut,
    output logic                     vbOut
);

    import videoTimingPkg::*;
    import videoPixelPkg::*;

    logic      hs;                              // raw sync and blank from the counters.
    logic      vs;
    logic      hb;
    logic      vb;
    palIndex_t backdrop;                        // cpu chosen fill colour.
    logic      scrEnable;
    logic      objEnable;
    scrPixel_t scrLinePixel;                    // scroll pixel read for the shown line.
    objPixel_t objLinePixel;                    // object pixel read for the shown line.
    logic      writeBank;
    logic      readBank;

    assign writeBank = lineBank(vrender);       // renderer fills the line ahead.
    assign readBank  = lineBank(vdump);         // display drains the line on screen.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster timing and cpu registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cpsTiming iTiming (
        .clk(clk), .reset(reset), .cen8(cen8),
        .hdump(hdump), .vdump(vdump), .vrender(vrender), .vrender1(vrender1),
        .start(start), .hs(hs), .vs(vs), .hb(hb), .vb(vb)
    );

    cpsVideoRegs iRegs (
        .clk(clk), .reset(reset), .regWrite(regWrite), .regAddr(regAddr), .regData(regData),
        .backdrop(backdrop), .scrEnable(scrEnable), .objEnable(objEnable)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one line buffer per layer.
    cpsLineBuffer #(.pixel_t(scrPixel_t)) iScrBuffer (
        .clk(clk), .reset(reset), .cen8(cen8),
        .write(scrWrite), .writeAddr(scrAddr), .writeData(scrPixel),
        .writeBank(writeBank), .readBank(readBank), .readAddr(hdump),
        .readData(scrLinePixel)
    );

    cpsLineBuffer #(.pixel_t(objPixel_t)) iObjBuffer (
        .clk(clk), .reset(reset), .cen8(cen8),
        .write(objWrite), .writeAddr(objAddr), .writeData(objPixel),
        .writeBank(writeBank), .readBank(readBank), .readAddr(hdump),
        .readData(objLinePixel)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // final priority mix.
    cpsLayerMix iMix (
        .clk(clk), .reset(reset), .cen8(cen8),
        .scrPixel(scrLinePixel), .objPixel(objLinePixel), .backdrop(backdrop),
        .scrEnable(scrEnable), .objEnable(objEnable),
        .hs(hs), .vs(vs), .hb(hb), .vb(vb),
        .pixIndex(pixIndex), .hsOut(hsOut), .vsOut(vsOut), .hbOut(hbOut), .vbOut(vbOut)
    );

endmodule

// File: bench/cpsVideo_assert.sv
`include "video_settings.svh"

module cpsVideo_assert (
    input logic                     clk,
    input logic                     reset,
    input logic                     cen8,
    input logic                     scrWrite,
    input logic                     objWrite,
    input logic                     regWrite,
    input videoTimingPkg::hcount_t  scrAddr,
    input videoTimingPkg::hcount_t  objAddr,
    input videoTimingPkg::hcount_t  hdump,
    input videoPixelPkg::scrPixel_t scrPixel,
    input videoPixelPkg::objPixel_t objPixel,
    input logic [2:0]               regAddr,
    input logic [15:0]              regData,
    input videoTimingPkg::vcount_t  vdump,
    input videoTimingPkg::vcount_t  vrender,
    input videoTimingPkg::vcount_t  vrender1,
    input logic                     start,
    input logic                     hsOut,
    input logic                     vsOut,
    input logic                     hbOut,
    input logic                     vbOut,
    input videoPixelPkg::palIndex_t pixIndex
);
    timeunit 1ns;
    timeprecision 1ps;

    import videoTimingPkg::*;
    import videoPixelPkg::*;

    localparam scrPixel_t scrEmpty = '{pal: '0, colour: colour_t'(`TRANSPARENT)};
    localparam objPixel_t objEmpty = '{prio: 1'b0, pal: '0, colour: colour_t'(`TRANSPARENT)};

    int        failCount = 0;                   // failed checks so far.
    int        lineSerial;                      // render lines since reset that tag each write.
    int        scrTag [1024];                   // serial of the line each slot was written for.
    int        objTag [1024];
    scrPixel_t scrShadow [1024];                // last pixel written per slot.
    objPixel_t objShadow [1024];
    palIndex_t backShadow;
    logic      scrOn;
    logic      objOn;
    logic      ticked;                          // at least one tick seen since reset.
    hcount_t   lastH;                           // counters as they were on the previous tick.
    vcount_t   lastVd;
    vcount_t   lastVr;
    vcount_t   lastVr1;
    logic      hsM;                             // raw sync and blank rebuilt from the counters.
    logic      vsM;
    logic      hbM;
    logic      vbM;
    logic [1:0] hsD;                            // two tick delay toward the mixer outputs.
    logic [1:0] vsD;
    logic [1:0] hbD;
    logic [1:0] vbD;
    scrPixel_t scrRead;                         // expected buffer readout.
    objPixel_t objRead;
    palIndex_t expPix;                          // expected pixIndex on the next tick.
    int        hsLen;                           // ticks of hsOut high so far.
    logic [9:0] readIdx;

    assign readIdx = {~lineSerial[0], hdump};   // slot of the line written one wrap ago.

    // object over scroll when it has priority or the scroll pixel shows nothing.
    function automatic palIndex_t mixModel(scrPixel_t s, objPixel_t o, logic blank);
        palIndex_t r;
        logic      sVis;
        sVis = scrOn && (s.colour != colour_t'(`TRANSPARENT));
        r    = backShadow;
        if (!blank && objOn && (o.colour != colour_t'(`TRANSPARENT)) && (o.prio || !sVis)) begin
            r = '{layer: layerObj, pal: o.pal, colour: o.colour};
        end else if (!blank && sVis) begin
            r = '{layer: layerScr, pal: s.pal, colour: s.colour};
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            backShadow <= '0;
            scrOn      <= 1'b1;
            objOn      <= 1'b1;
            for (int i = 0; i < 1024; i++) begin
                scrTag[i] <= -8;                // no slot belongs to any line yet.
                objTag[i] <= -8;
            end
        end else begin
            if (scrWrite) begin
                scrShadow[{lineSerial[0], scrAddr}] <= scrPixel;
                scrTag[{lineSerial[0], scrAddr}]    <= lineSerial;
            end
            if (objWrite) begin
                objShadow[{lineSerial[0], objAddr}] <= objPixel;
                objTag[{lineSerial[0], objAddr}]    <= lineSerial;
            end
            if (regWrite && regAddr == 3'd0) begin
                backShadow <= '{layer: layerBack, pal: regData[8:4], colour: regData[3:0]};
            end
            if (regWrite && regAddr == 3'd1) begin
                scrOn <= regData[0];
                objOn <= regData[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lineSerial <= 0;
            ticked     <= 1'b0;
            {hsM, vsM, hbM, vbM} <= 4'b0011;
            {hsD, vsD, hbD, vbD} <= 8'b0000_1111;
            scrRead    <= scrEmpty;
            objRead    <= objEmpty;
            expPix     <= '0;
            hsLen      <= 0;
        end else if (cen8) begin
            ticked  <= 1'b1;
            lastH   <= hdump;
            lastVd  <= vdump;
            lastVr  <= vrender;
            lastVr1 <= vrender1;
            hbM     <= (hdump >= hcount_t'(`HB_START)) || (hdump < hcount_t'(`HB_END));
            if (hdump == hcount_t'(`HS_SET)) hsM <= 1'b1;
            else if (hdump == hcount_t'(`HS_CLR)) hsM <= 1'b0;
            if (vdump == vcount_t'(`VS_SET)) vsM <= 1'b1;
            else if (vdump == vcount_t'(`VS_CLR)) vsM <= 1'b0;
            if (hdump == hcount_t'(`HTOTAL - 1)) begin
                vbM        <= (vdump < vcount_t'(`VB_FIRST)) || (vdump > vcount_t'(`VB_LAST));
                lineSerial <= lineSerial + 1;   // the next line gets a fresh tag.
            end
            hsD     <= {hsD[0], hsM};
            vsD     <= {vsD[0], vsM};
            hbD     <= {hbD[0], hbM};
            vbD     <= {vbD[0], vbM};
            scrRead <= (scrTag[readIdx] == lineSerial - 1) ? scrShadow[readIdx] : scrEmpty;
            objRead <= (objTag[readIdx] == lineSerial - 1) ? objShadow[readIdx] : objEmpty;
            expPix  <= mixModel(scrRead, objRead, hbD[0] || vbD[0]);
            hsLen   <= hsOut ? hsLen + 1 : 0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) $fell(reset) |-> !hsOut && !vsOut && !start && hbOut && vbOut)
        else begin
            failCount++;
            $error("FAIL %0t: outputs not idle after reset", $time);
        end
    assert property (@(posedge clk) disable iff (reset) cen8 && ticked |->
        hdump == hcount_t'(lastH + 1) && start == (lastH == hcount_t'(`HTOTAL - 1)))
        else begin
            failCount++;
            $error("FAIL %0t: hdump %0d after %0d", $time, hdump, lastH);
        end
    assert property (@(posedge clk) disable iff (reset)
        cen8 && ticked && lastH == hcount_t'(`HTOTAL - 1) |-> vdump == lastVr &&
        vrender == lastVr1 && vrender1 == ((lastVr1 == `VTOTAL - 1) ? '0 : lastVr1 + 1'b1))
        else begin
            failCount++;
            $error("FAIL %0t: line counters at wrap", $time);
        end
    assert property (@(posedge clk) disable iff (reset)
        cen8 && ticked && lastH != hcount_t'(`HTOTAL - 1) |->
        vdump == lastVd && vrender == lastVr && vrender1 == lastVr1)
        else begin
            failCount++;
            $error("FAIL %0t: line counters moved mid line", $time);
        end
    assert property (@(posedge clk) disable iff (reset)
        cen8 |-> {hsOut, vsOut, hbOut, vbOut} == {hsD[1], vsD[1], hbD[1], vbD[1]})
        else begin
            failCount++;
            $error("FAIL %0t: sync or blank out of step", $time);
        end
    assert property (@(posedge clk) disable iff (reset)
        cen8 && hsLen > 0 && !hsOut |-> hsLen == 36)
        else begin
            failCount++;
            $error("FAIL %0t: hsync lasted %0d ticks", $time, hsLen);
        end
    assert property (@(posedge clk) disable iff (reset) cen8 |-> pixIndex == expPix)
        else begin
            failCount++;
            $error("FAIL %0t: pixIndex %h, want %h", $time, pixIndex, expPix);
        end

endmodule

bind cpsVideo cpsVideo_assert iAssert (.*);

// File: bench/cpsVideoTb.sv
`include "video_settings.svh"

module cpsVideoTb;
    timeunit 1ns;
    timeprecision 1ps;

    import videoTimingPkg::*;
    import videoPixelPkg::*;

    localparam int runClocks   = 2 * `VTOTAL * `HTOTAL * 2 + 1100; // two frames and the sweep.
    localparam int limitClocks = runClocks + runClocks / 10;
    localparam int lineClocks  = 2 * `HTOTAL;   // cen8 ticks on every second clock.

    logic      clk;
    logic      reset;
    logic      cen8;
    logic      scrWrite;
    hcount_t   scrAddr;
    scrPixel_t scrPixel;
    logic      objWrite;
    hcount_t   objAddr;
    objPixel_t objPixel;
    logic      regWrite;
    logic [2:0]  regAddr;
    logic [15:0] regData;
    hcount_t   hdump;
    vcount_t   vdump;
    vcount_t   vrender;
    vcount_t   vrender1;
    logic      start;
    palIndex_t pixIndex;
    logic      hsOut;
    logic      vsOut;
    logic      hbOut;
    logic      vbOut;
    int        seed = 43;
    int        cycleCount = 0;
    int        timeoutCount = 0;
    int        missCount = 0;                   // start pulses that never came.

    cpsVideo i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) cen8 = ~cen8;         // one pixel tick every two clocks.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic finishRun();
        int assertFails;
        assertFails = i_dut.iAssert.failCount;
        $display("errors: assertions %0d, missed starts %0d, timeouts %0d",
                 assertFails, missCount, timeoutCount);
        if (assertFails + missCount + timeoutCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount == limitClocks) begin
            timeoutCount = 1;
            $display("timeout after %0d clocks, the run did not finish", cycleCount);
            finishRun();
        end
    end

    task automatic waitForStart();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!start && waited < 2 * lineClocks) begin
            @(negedge clk);
            waited++;
        end
        if (!start) begin
            missCount++;
            $display("no line start pulse within two lines at %0t", $time);
        end
    endtask

    task automatic writeReg(input logic [2:0] addr, input logic [15:0] data);
        regWrite = 1'b1;
        regAddr  = addr;
        regData  = data;
        @(negedge clk);
        regWrite = 1'b0;
    endtask

    // eight random pixels per layer with about a quarter of them see-through.
    task automatic drawLine();
        int r;
        for (int i = 0; i < 8; i++) begin
            r        = $random(seed);
            scrWrite = 1'b1;
            scrAddr  = hcount_t'(r);
            scrPixel = scrPixel_t'(r >>> 9);
            if (r[30:29] == 2'b00) scrPixel.colour = colour_t'(`TRANSPARENT);
            r        = $random(seed);
            objWrite = 1'b1;
            objAddr  = hcount_t'(r);
            objPixel = objPixel_t'(r >>> 9);
            if (r[30:29] == 2'b00) objPixel.colour = colour_t'(`TRANSPARENT);
            @(negedge clk);
        end
        scrWrite = 1'b0;
        objWrite = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        {cen8, scrWrite, objWrite, regWrite} = '0;
        {scrAddr, scrPixel, objAddr, objPixel, regAddr, regData} = '0;
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        while (cycleCount < runClocks) begin
            waitForStart();
            if (vdump == 9'd40) begin
                writeReg(3'd1, 16'h0002);       // objects only.
                writeReg(3'd0, 16'h01A5);
            end else if (vdump == 9'd80) begin
                writeReg(3'd1, 16'h0001);       // scroll only.
                writeReg(3'd0, 16'h00F3);
            end else if (vdump == 9'd120) begin
                writeReg(3'd1, 16'h0003);
                writeReg(3'd5, 16'hFFFC);       // nothing lives at this address.
            end
            drawLine();
        end
        finishRun();
    end

endmodule

// File: cpsVideo.f
+incdir+include
source/videoTimingPkg.sv
source/videoPixelPkg.sv
source/cpsTiming.sv
source/cpsVideoRegs.sv
source/cpsLineBuffer.sv
source/cpsLayerMix.sv
source/cpsVideo.sv
bench/cpsVideo_assert.sv
bench/cpsVideoTb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpsVideo testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --timescale 1ns/1ps \
    -f cpsVideo.f --top-module cpsVideoTb -o cpsVideoSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cpsVideoSim +verilator+error+limit+100000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
